// File: Bender.yml
package:
  name: exec_slice

dependencies: {}

sources:
  # shared package first
  - files:
      - src/core_pkg.sv
  # design
  - files:
      - src/reg_file.sv
      - src/operand_read.sv
      - src/alu_execute.sv
      - src/exec_slice_top.sv
  # testbench
  - target: test
    files:
      - tests/exec_slice_tb.sv

// File: exec_slice.f
src/core_pkg.sv
src/reg_file.sv
src/operand_read.sv
src/alu_execute.sv
src/exec_slice_top.sv
tests/exec_slice_tb.sv

// File: src/alu_execute.sv
`timescale 1ns/10ps

module alu_execute (
	input  logic                clk,
	input  logic                reset,

	// from operand read
	input  logic                op_vld,
	input  core_pkg::alu_mode_t op_mode,
	input  core_pkg::data_t     op_a,
	input  core_pkg::data_t     op_b,
	input  core_pkg::data_t     op_imm,
	input  core_pkg::preg_t     op_dst,
	input  logic                op_reg_wrt,
	input  core_pkg::rob_idx_t  op_idx,

	// execute stage forwarding
	output logic                ex_fwd_vld,
	output core_pkg::preg_t     ex_fwd_preg,
	output core_pkg::data_t     ex_fwd_data,

	// result register
	output logic                wb_vld,
	output logic                wb_reg_wrt,
	output logic                wb_wrt_en,
	output core_pkg::preg_t     wb_preg,
	output core_pkg::data_t     wb_data,
	output core_pkg::rob_idx_t  wb_idx
);
	import core_pkg::*;

	data_t              result;
	logic [SHAMT_W-1:0] shamt;

	assign shamt = op_b[SHAMT_W-1:0];

	// all arithmetic wraps at the data width
	always_comb begin
		case (op_mode)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			ALU_SHL: result = op_a << shamt;
			ALU_SHR: result = op_a >> shamt;
			ALU_LDI: result = op_imm;
			default: result = '0;
		endcase
	end

	assign ex_fwd_vld  = op_vld & op_reg_wrt;
	assign ex_fwd_preg = op_dst;
	assign ex_fwd_data = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_vld <= 1'b0;
		end else begin
			wb_vld <= op_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (op_vld) begin
			wb_reg_wrt <= op_reg_wrt;
			wb_preg    <= op_dst;
			wb_data    <= result;
			wb_idx     <= op_idx;
		end
	end

	// register file write and writeback forwarding qualifier
	assign wb_wrt_en = wb_vld & wb_reg_wrt;

endmodule

// File: src/core_pkg.sv
package core_pkg;

	// datapath and tag widths
	localparam int DATA_W  = 16;
	localparam int PREG_W  = 6;
	localparam int IDX_W   = 6;

	// shift amount covers one data word
	localparam int SHAMT_W = $clog2(DATA_W);

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [IDX_W-1:0]  rob_idx_t;

	// alu operation select
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SHL = 3'd5,
		ALU_SHR = 3'd6,
		ALU_LDI = 3'd7
	} alu_mode_t;

endpackage

// File: src/exec_slice_top.sv
`timescale 1ns/10ps

module exec_slice_top #(
	parameter int NUM_PREGS = 64
) (
	input  logic                clk,
	input  logic                reset,

	// issue
	input  logic                iss_vld,
	input  core_pkg::alu_mode_t iss_mode,
	input  core_pkg::preg_t     iss_src1,
	input  core_pkg::preg_t     iss_src2,
	input  core_pkg::data_t     iss_imm,
	input  logic                iss_imm_vld,
	input  core_pkg::preg_t     iss_dst,
	input  logic                iss_reg_wrt,
	input  core_pkg::rob_idx_t  iss_idx,

	// completion
	output logic                done_vld,
	output core_pkg::rob_idx_t  done_idx,
	output core_pkg::preg_t     done_preg,
	output core_pkg::data_t     done_data,
	output logic                done_reg_wrt
);
	import core_pkg::*;

	// register file read
	preg_t     rf_addr1;
	preg_t     rf_addr2;
	data_t     rf_data1;
	data_t     rf_data2;

	// read to execute
	logic      op_vld;
	alu_mode_t op_mode;
	data_t     op_a;
	data_t     op_b;
	data_t     op_imm;
	preg_t     op_dst;
	logic      op_reg_wrt;
	rob_idx_t  op_idx;

	// execute forwarding
	logic      ex_fwd_vld;
	preg_t     ex_fwd_preg;
	data_t     ex_fwd_data;

	// writeback
	logic      wb_vld;
	logic      wb_reg_wrt;
	logic      wb_wrt_en;
	preg_t     wb_preg;
	data_t     wb_data;
	rob_idx_t  wb_idx;

	operand_read u_operand_read (
		.clk         (clk),
		.reset       (reset),
		.iss_vld     (iss_vld),
		.iss_mode    (iss_mode),
		.iss_src1    (iss_src1),
		.iss_src2    (iss_src2),
		.iss_imm     (iss_imm),
		.iss_imm_vld (iss_imm_vld),
		.iss_dst     (iss_dst),
		.iss_reg_wrt (iss_reg_wrt),
		.iss_idx     (iss_idx),
		.rf_addr1    (rf_addr1),
		.rf_addr2    (rf_addr2),
		.rf_data1    (rf_data1),
		.rf_data2    (rf_data2),
		.ex_fwd_vld  (ex_fwd_vld),
		.ex_fwd_preg (ex_fwd_preg),
		.ex_fwd_data (ex_fwd_data),
		// wb source qualifies on the write enable
		.wb_fwd_vld  (wb_wrt_en),
		.wb_fwd_preg (wb_preg),
		.wb_fwd_data (wb_data),
		.op_vld      (op_vld),
		.op_mode     (op_mode),
		.op_a        (op_a),
		.op_b        (op_b),
		.op_imm      (op_imm),
		.op_dst      (op_dst),
		.op_reg_wrt  (op_reg_wrt),
		.op_idx      (op_idx)
	);

	alu_execute u_alu_execute (
		.clk         (clk),
		.reset       (reset),
		.op_vld      (op_vld),
		.op_mode     (op_mode),
		.op_a        (op_a),
		.op_b        (op_b),
		.op_imm      (op_imm),
		.op_dst      (op_dst),
		.op_reg_wrt  (op_reg_wrt),
		.op_idx      (op_idx),
		.ex_fwd_vld  (ex_fwd_vld),
		.ex_fwd_preg (ex_fwd_preg),
		.ex_fwd_data (ex_fwd_data),
		.wb_vld      (wb_vld),
		.wb_reg_wrt  (wb_reg_wrt),
		.wb_wrt_en   (wb_wrt_en),
		.wb_preg     (wb_preg),
		.wb_data     (wb_data),
		.wb_idx      (wb_idx)
	);

	reg_file #(
		.NUM_PREGS (NUM_PREGS)
	) u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.rd_addr1 (rf_addr1),
		.rd_addr2 (rf_addr2),
		.rd_data1 (rf_data1),
		.rd_data2 (rf_data2),
		.wr_en    (wb_wrt_en),
		.wr_addr  (wb_preg),
		.wr_data  (wb_data)
	);

	// completion comes straight from the result register
	assign done_vld     = wb_vld;
	assign done_idx     = wb_idx;
	assign done_preg    = wb_preg;
	assign done_data    = wb_data;
	assign done_reg_wrt = wb_reg_wrt;

endmodule

// File: src/operand_read.sv
`timescale 1ns/10ps

module operand_read (
	input  logic                clk,
	input  logic                reset,

	// issue
	input  logic                iss_vld,
	input  core_pkg::alu_mode_t iss_mode,
	input  core_pkg::preg_t     iss_src1,
	input  core_pkg::preg_t     iss_src2,
	input  core_pkg::data_t     iss_imm,
	input  logic                iss_imm_vld,
	input  core_pkg::preg_t     iss_dst,
	input  logic                iss_reg_wrt,
	input  core_pkg::rob_idx_t  iss_idx,

	// register file
	output core_pkg::preg_t     rf_addr1,
	output core_pkg::preg_t     rf_addr2,
	input  core_pkg::data_t     rf_data1,
	input  core_pkg::data_t     rf_data2,

	// forwarding from execute
	input  logic                ex_fwd_vld,
	input  core_pkg::preg_t     ex_fwd_preg,
	input  core_pkg::data_t     ex_fwd_data,

	// forwarding from writeback
	input  logic                wb_fwd_vld,
	input  core_pkg::preg_t     wb_fwd_preg,
	input  core_pkg::data_t     wb_fwd_data,

	// to execute
	output logic                op_vld,
	output core_pkg::alu_mode_t op_mode,
	output core_pkg::data_t     op_a,
	output core_pkg::data_t     op_b,
	output core_pkg::data_t     op_imm,
	output core_pkg::preg_t     op_dst,
	output logic                op_reg_wrt,
	output core_pkg::rob_idx_t  op_idx
);
	import core_pkg::*;

	data_t src1_val;
	data_t src2_val;
	data_t opnd_b;

	assign rf_addr1 = iss_src1;
	assign rf_addr2 = iss_src2;

	function automatic data_t fwd_select(input preg_t src, input data_t rf_val);
		data_t val;
		// execute holds the younger result so it is checked first
		if (ex_fwd_vld && (ex_fwd_preg == src)) begin
			val = ex_fwd_data;
		end else if (wb_fwd_vld && (wb_fwd_preg == src)) begin
			val = wb_fwd_data;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	always_comb begin
		src1_val = fwd_select(iss_src1, rf_data1);
		src2_val = fwd_select(iss_src2, rf_data2);
		opnd_b   = iss_imm_vld ? iss_imm : src2_val;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_vld <= 1'b0;
		end else begin
			op_vld <= iss_vld;
		end
	end

	// fields only load on a real issue
	always_ff @(posedge clk) begin
		if (iss_vld) begin
			op_mode    <= iss_mode;
			op_a       <= src1_val;
			op_b       <= opnd_b;
			op_imm     <= iss_imm;
			op_dst     <= iss_dst;
			op_reg_wrt <= iss_reg_wrt;
			op_idx     <= iss_idx;
		end
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file #(
	parameter int NUM_PREGS = 64
) (
	input  logic            clk,
	input  logic            reset,

	// read ports
	input  core_pkg::preg_t rd_addr1,
	input  core_pkg::preg_t rd_addr2,
	output core_pkg::data_t rd_data1,
	output core_pkg::data_t rd_data2,

	// write port
	input  logic            wr_en,
	input  core_pkg::preg_t wr_addr,
	input  core_pkg::data_t wr_data
);
	import core_pkg::*;

	data_t regs [NUM_PREGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_PREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// plain async read
	// a write landing this cycle is picked up by operand_read forwarding
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

// File: tests/exec_slice_tb.sv
`timescale 1ns/10ps

module exec_slice_tb;
	import core_pkg::*;

	localparam int NUM_DIRECTED   = 14;
	localparam int NUM_RANDOM     = 400;
	localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 2 + 16 + 50;

	logic      clk;
	logic      reset;
	logic      iss_vld;
	alu_mode_t iss_mode;
	preg_t     iss_src1;
	preg_t     iss_src2;
	data_t     iss_imm;
	logic      iss_imm_vld;
	preg_t     iss_dst;
	logic      iss_reg_wrt;
	rob_idx_t  iss_idx;
	logic      done_vld;
	rob_idx_t  done_idx;
	preg_t     done_preg;
	data_t     done_data;
	logic      done_reg_wrt;

	data_t     shadow [64];
	data_t     exp_data_q [$];
	preg_t     exp_preg_q [$];
	rob_idx_t  exp_idx_q [$];
	logic      exp_wrt_q [$];
	int        exp_edge_q [$];

	int          cycle;
	int          value_errs;
	int          timing_errs;
	int          other_errs;
	logic [31:0] seed;
	rob_idx_t    next_idx;

	exec_slice_top #(
		.NUM_PREGS (64)
	) DUT (
		.clk          (clk),
		.reset        (reset),
		.iss_vld      (iss_vld),
		.iss_mode     (iss_mode),
		.iss_src1     (iss_src1),
		.iss_src2     (iss_src2),
		.iss_imm      (iss_imm),
		.iss_imm_vld  (iss_imm_vld),
		.iss_dst      (iss_dst),
		.iss_reg_wrt  (iss_reg_wrt),
		.iss_idx      (iss_idx),
		.done_vld     (done_vld),
		.done_idx     (done_idx),
		.done_preg    (done_preg),
		.done_data    (done_data),
		.done_reg_wrt (done_reg_wrt)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// expected result straight from the mode rules
	function automatic data_t alu_ref(input alu_mode_t mode, input data_t a, input data_t b,
			input data_t imm);
		case (mode)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SHL: return a << b[3:0];
			ALU_SHR: return a >> b[3:0];
			default: return imm;
		endcase
	endfunction

	task automatic check_data(input string what, input data_t got, input data_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_preg(input string what, input preg_t got, input preg_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_idx(input string what, input rob_idx_t got, input rob_idx_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic issue_instr(input alu_mode_t mode, input preg_t src1, input preg_t src2,
			input data_t imm, input logic imm_vld, input preg_t dst, input logic wrt);
		@(posedge clk);
		iss_vld     <= 1'b1;
		iss_mode    <= mode;
		iss_src1    <= src1;
		iss_src2    <= src2;
		iss_imm     <= imm;
		iss_imm_vld <= imm_vld;
		iss_dst     <= dst;
		iss_reg_wrt <= wrt;
		iss_idx     <= next_idx;
		next_idx    = next_idx + 1'b1;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		iss_vld <= 1'b0;
	endtask

	// reference model sees each issue in program order
	always @(posedge clk) begin : model
		data_t a;
		data_t b;
		data_t res;
		if (!reset && iss_vld === 1'b1) begin
			a   = shadow[iss_src1];
			b   = iss_imm_vld ? iss_imm : shadow[iss_src2];
			res = alu_ref(iss_mode, a, b, iss_imm);
			if (iss_reg_wrt) begin
				shadow[iss_dst] = res;
			end
			exp_data_q.push_back(res);
			exp_preg_q.push_back(iss_dst);
			exp_idx_q.push_back(iss_idx);
			exp_wrt_q.push_back(iss_reg_wrt);
			exp_edge_q.push_back(cycle);
		end
	end

	always @(posedge clk) begin : compare
		int issue_edge;
		if (reset) begin
			if (cycle > 0 && done_vld !== 1'b0) begin
				other_errs++;
				$display("done_vld is not low during reset at %0t", $time);
			end
		end else if (done_vld === 1'b1) begin
			if (exp_data_q.size() == 0) begin
				other_errs++;
				$display("done_vld high at %0t with no instruction outstanding", $time);
			end else begin
				issue_edge = exp_edge_q.pop_front();
				check_data("done_data", done_data, exp_data_q.pop_front());
				check_preg("done_preg", done_preg, exp_preg_q.pop_front());
				check_idx("done_idx", done_idx, exp_idx_q.pop_front());
				check_flag("done_reg_wrt", done_reg_wrt, exp_wrt_q.pop_front());
				if (cycle != issue_edge + 2) begin
					timing_errs++;
					$display("Error at %0t: completion %0d edges after issue, expected 2",
						$time, cycle - issue_edge);
				end
			end
		end else if (done_vld !== 1'b0) begin
			other_errs++;
			$display("done_vld is unknown after reset at %0t", $time);
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * 10);
		$display("timeout, the run did not finish in %0d cycles", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] r2;
		cycle       = 0;
		value_errs  = 0;
		timing_errs = 0;
		other_errs  = 0;
		seed        = 32'h27f5;
		next_idx    = '0;
		for (int i = 0; i < 64; i++) begin
			shadow[i] = '0;
		end
		reset       = 1'b1;
		iss_vld     = 1'b0;
		iss_mode    = ALU_ADD;
		iss_src1    = '0;
		iss_src2    = '0;
		iss_imm     = '0;
		iss_imm_vld = 1'b0;
		iss_dst     = '0;
		iss_reg_wrt = 1'b0;
		iss_idx     = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		idle_cycle();
		idle_cycle();

		// fresh registers read zero
		issue_instr(ALU_ADD, 6'd3, 6'd4, 16'h0000, 1'b0, 6'd1, 1'b1);
		issue_instr(ALU_OR,  6'd5, 6'd6, 16'h0000, 1'b0, 6'd2, 1'b1);
		// wrap, shifts by low 4 bits, both forwarding stages
		issue_instr(ALU_LDI, 6'd0, 6'd0, 16'hfff0, 1'b1, 6'd1, 1'b1);
		issue_instr(ALU_ADD, 6'd1, 6'd0, 16'h0025, 1'b1, 6'd2, 1'b1);
		issue_instr(ALU_SUB, 6'd2, 6'd1, 16'h0000, 1'b0, 6'd3, 1'b1);
		issue_instr(ALU_SHL, 6'd1, 6'd0, 16'h0013, 1'b1, 6'd4, 1'b1);
		issue_instr(ALU_SHR, 6'd1, 6'd0, 16'hfff8, 1'b1, 6'd5, 1'b1);
		issue_instr(ALU_AND, 6'd4, 6'd5, 16'h0000, 1'b0, 6'd6, 1'b1);
		issue_instr(ALU_XOR, 6'd4, 6'd1, 16'h0000, 1'b0, 6'd7, 1'b1);
		// r1 keeps its value without a register write
		issue_instr(ALU_LDI, 6'd0, 6'd0, 16'h1234, 1'b1, 6'd1, 1'b0);
		issue_instr(ALU_ADD, 6'd1, 6'd0, 16'h0000, 1'b1, 6'd2, 1'b1);
		// younger value wins when both stages hold r5
		issue_instr(ALU_ADD, 6'd1, 6'd0, 16'h0001, 1'b1, 6'd5, 1'b1);
		issue_instr(ALU_LDI, 6'd0, 6'd0, 16'h0002, 1'b1, 6'd5, 1'b1);
		issue_instr(ALU_ADD, 6'd5, 6'd5, 16'h0000, 1'b0, 6'd6, 1'b1);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			seed = lcg_next(seed);
			r    = seed;
			seed = lcg_next(seed);
			r2   = seed;
			if (r[31:30] != 2'b00) begin
				issue_instr(alu_mode_t'(r[29:27]), {3'b000, r[26:24]}, {3'b000, r[23:21]},
					r2[31:16], r[20], {3'b000, r[19:17]}, r[16] | r[15]);
			end else begin
				idle_cycle();
			end
		end
		repeat (6) idle_cycle();

		if (exp_data_q.size() != 0) begin
			other_errs++;
			$display("%0d expected completions never arrived", exp_data_q.size());
		end
		$display("value errors: %0d, timing errors: %0d, other errors: %0d",
			value_errs, timing_errs, other_errs);
		if (value_errs + timing_errs + other_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
